/* project.f */
pdp_isa_pkg.sv
pdp_core_pkg.sv
register_file.sv
single_operand_alu.sv
double_operand_alu.sv
result_merge.sv
instruction_sequencer.sv
pdp_core.sv
pdp_checker.sv
tb_pdp_core.sv

/* tb_pdp_core.sv */
`timescale 1ns/1ps

module tb_pdp_core;

	localparam int NUM_TESTS = 49;
	localparam int CYCLE_LIMIT = 200 * NUM_TESTS;
	localparam pdp_core_pkg::word_t PROG_BASE = 16'o000200;

	logic clock;
	logic reset;
	pdp_core_pkg::word_t start_pc;
	pdp_core_pkg::word_t end_pc;
	pdp_core_pkg::word_t wb_dat_r;
	logic wb_ack;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	pdp_core_pkg::word_t wb_adr;
	pdp_core_pkg::word_t wb_dat_w;
	logic done;

	pdp_core_pkg::word_t mem [0:255];
	pdp_core_pkg::word_t instr0;
	pdp_core_pkg::word_t instr1;
	int test_id;
	int cycles;
	int wait_left;
	logic busy;
	int checked;
	int failed;

	pdp_core uut (.*);

	pdp_checker u_checker (
		.clock(clock),
		.reset(reset),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_ack(wb_ack),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.done(done),
		.test_id(test_id),
		.instr0(instr0),
		.instr1(instr1),
		.checked(checked),
		.failed(failed)
	);

	always #4 clock = ~clock;

	// memory contents depend on every address bit
	function automatic pdp_core_pkg::word_t fill_word(input pdp_core_pkg::word_t addr);
		return (addr * 16'd13) ^ 16'h5a5a;
	endfunction

	function automatic pdp_isa_pkg::single_op_t single_op_at(input int i);
		pdp_isa_pkg::single_op_t op;
		op = op.first();
		repeat (i) op = op.next();
		return op;
	endfunction

	function automatic pdp_isa_pkg::branch_op_t branch_op_at(input int i);
		pdp_isa_pkg::branch_op_t op;
		op = op.first();
		repeat (i) op = op.next();
		return op;
	endfunction

	// destination is always R0 in register mode
	function automatic pdp_core_pkg::word_t encode_double(input pdp_isa_pkg::double_op_t op,
		input logic [2:0] src_mode, input logic [2:0] src_reg);
		return {op, src_mode, src_reg, 3'd0, 3'd0};
	endfunction

	// 0..10 single, 11..17 double, 18..47 branch, 48 backward branch
	task automatic load_program(input int id);
		pdp_core_pkg::word_t prog [0:3];
		pdp_core_pkg::word_t store;
		int n;
		store = {4'o01, 3'd0, 3'd0, 3'd1, 3'd5};
		prog[2] = 16'd0;
		prog[3] = 16'd0;
		n = 2;
		for (int a = 0; a < 256; a++)
			mem[a] = fill_word(16'(a * 2));
		if (id < 11)
		begin
			prog[0] = {single_op_at(id), 6'o00};
			prog[1] = store;
		end
		else if (id < 18)
		begin
			case (id - 11)
				0: prog[0] = encode_double(pdp_isa_pkg::ADD, 3'd0, 3'd1);
				1: prog[0] = encode_double(pdp_isa_pkg::SUB, 3'd0, 3'd1);
				2: prog[0] = encode_double(pdp_isa_pkg::BIC, 3'd0, 3'd2);
				3: prog[0] = encode_double(pdp_isa_pkg::BIS, 3'd0, 3'd1);
				4: prog[0] = encode_double(pdp_isa_pkg::MOV, 3'd0, 3'd3);
				5: prog[0] = encode_double(pdp_isa_pkg::ADD, 3'd1, 3'd2);
				default: prog[0] = encode_double(pdp_isa_pkg::SUB, 3'd1, 3'd2);
			endcase
			prog[1] = store;
		end
		else if (id < 48)
		begin
			// compare, then a branch over the marker store
			prog[0] = encode_double(pdp_isa_pkg::CMP, 3'd0, ((id - 18) / 15 == 0) ? 3'd1 : 3'd0);
			prog[1] = {branch_op_at((id - 18) % 15), 8'd1};
			prog[2] = store;
			n = 3;
		end
		else
		begin
			prog[0] = {pdp_isa_pkg::BR, 8'd2};
			prog[1] = store;
			prog[2] = {pdp_isa_pkg::BR, 8'd1};
			prog[3] = {pdp_isa_pkg::BR, 8'hfd};
			n = 4;
		end
		for (int i = 0; i < n; i++)
			mem[PROG_BASE[8:1] + i] = prog[i];
		start_pc <= PROG_BASE;
		end_pc <= PROG_BASE + 16'(2 * n);
		instr0 <= prog[0];
		instr1 <= prog[1];
		test_id <= id;
	endtask

	task automatic run_test(input int id);
		@(posedge clock);
		reset <= 1'b1;
		load_program(id);
		repeat (2) @(posedge clock);
		reset <= 1'b0;
		while (!done)
			@(posedge clock);
		repeat (3) @(posedge clock);
	endtask

	// wishbone memory with 0 to 2 wait states
	always @(posedge clock)
	begin
		int w;
		if (reset)
		begin
			wb_ack <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			wb_ack <= 1'b0;
			if (wb_cyc && wb_stb && !wb_ack)
			begin
				w = busy ? wait_left : int'($urandom % 3);
				if (w == 0)
				begin
					wb_ack <= 1'b1;
					busy <= 1'b0;
					if (wb_we)
						mem[wb_adr[8:1]] <= wb_dat_w;
					else
						wb_dat_r <= mem[wb_adr[8:1]];
				end
				else
				begin
					busy <= 1'b1;
					wait_left <= w - 1;
				end
			end
		end
	end

	always @(posedge clock)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: done did not rise in test %0d within %0d cycles", test_id,
				CYCLE_LIMIT);
			$display("TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		void'($urandom(26));
		clock = 1'b0;
		reset = 1'b1;
		start_pc = '0;
		end_pc = '0;
		wb_dat_r = '0;
		wb_ack = 1'b0;
		busy = 1'b0;
		wait_left = 0;
		cycles = 0;
		test_id = 0;
		instr0 = '0;
		instr1 = '0;
		for (int id = 0; id < NUM_TESTS; id++)
			run_test(id);
		@(posedge clock);
		$display("%0d of %0d tests checked, %0d failures", checked, NUM_TESTS, failed);
		if (failed == 0 && checked == NUM_TESTS)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* pdp_checker.sv */
`timescale 1ns/1ps

module pdp_checker (
	input logic clock,
	input logic reset,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic wb_ack,
	input pdp_core_pkg::word_t wb_adr,
	input pdp_core_pkg::word_t wb_dat_w,
	input logic done,
	input int test_id,
	input pdp_core_pkg::word_t instr0,
	input pdp_core_pkg::word_t instr1,
	output int checked,
	output int failed
);

	// marker stores always go through R5
	localparam pdp_core_pkg::word_t STORE_ADDR = pdp_core_pkg::REG_RESET_VALUES[5];

	int stores;
	pdp_core_pkg::word_t first_data;
	pdp_core_pkg::word_t first_adr;
	logic done_q;
	logic bus_fault;

	function automatic pdp_core_pkg::word_t fill_word(input pdp_core_pkg::word_t addr);
		return (addr * 16'd13) ^ 16'h5a5a;
	endfunction

	function automatic string test_name(input int id);
		string kind;
		kind = (id < 11) ? "single" : (id < 18) ? "double" : (id < 48) ? "branch" : "br_back";
		return $sformatf("%s_%0d(%06o,%06o)", kind, id, instr0, instr1);
	endfunction

	// standard branch table
	function automatic logic taken(input logic [7:0] op, input logic n, input logic z,
		input logic v, input logic c);
		case (pdp_isa_pkg::branch_op_t'(op))
			pdp_isa_pkg::BR: return 1'b1;
			pdp_isa_pkg::BNE: return !z;
			pdp_isa_pkg::BEQ: return z;
			pdp_isa_pkg::BGE: return n == v;
			pdp_isa_pkg::BLT: return n != v;
			pdp_isa_pkg::BGT: return !z && n == v;
			pdp_isa_pkg::BLE: return z || n != v;
			pdp_isa_pkg::BPL: return !n;
			pdp_isa_pkg::BMI: return n;
			pdp_isa_pkg::BHI: return !c && !z;
			pdp_isa_pkg::BLOS: return c || z;
			pdp_isa_pkg::BVC: return !v;
			pdp_isa_pkg::BVS: return v;
			pdp_isa_pkg::BCC: return !c;
			default: return c;
		endcase
	endfunction

	// bit 16 flags a due store and the low bits hold the stored word
	function automatic logic [16:0] expected_store(input int id, input pdp_core_pkg::word_t i0,
		input pdp_core_pkg::word_t i1);
		pdp_core_pkg::word_t s;
		pdp_core_pkg::word_t d;
		pdp_core_pkg::word_t r;
		d = pdp_core_pkg::REG_RESET_VALUES[i0[2:0]];
		s = pdp_core_pkg::REG_RESET_VALUES[i0[8:6]];
		r = d;
		if (id < 11)
		begin
			// carry is clear after reset
			case (pdp_isa_pkg::single_op_t'(i0[15:6]))
				pdp_isa_pkg::SWAB: r = {d[7:0], d[15:8]};
				pdp_isa_pkg::CLR: r = 16'd0;
				pdp_isa_pkg::COM: r = ~d;
				pdp_isa_pkg::INC: r = d + 16'd1;
				pdp_isa_pkg::DEC: r = d - 16'd1;
				pdp_isa_pkg::NEG: r = -d;
				pdp_isa_pkg::ROR: r = {1'b0, d[15:1]};
				pdp_isa_pkg::ROL: r = {d[14:0], 1'b0};
				pdp_isa_pkg::ASR: r = {d[15], d[15:1]};
				pdp_isa_pkg::ASL: r = {d[14:0], 1'b0};
				default: r = d;
			endcase
			return {1'b1, r};
		end
		if (id < 18)
		begin
			if (i0[11:9] == 3'd1)
				s = fill_word(s);
			case (pdp_isa_pkg::double_op_t'(i0[15:12]))
				pdp_isa_pkg::ADD: r = d + s;
				pdp_isa_pkg::SUB: r = d - s;
				pdp_isa_pkg::BIC: r = d & ~s;
				pdp_isa_pkg::BIS: r = d | s;
				default: r = s;
			endcase
			return {1'b1, r};
		end
		if (id < 48)
		begin
			r = s - d;
			return {!taken(i1[15:8], r[15], r == 16'd0,
				s[15] != d[15] && r[15] != s[15], s < d),
				pdp_core_pkg::REG_RESET_VALUES[0]};
		end
		return {1'b1, pdp_core_pkg::REG_RESET_VALUES[0]};
	endfunction

	task automatic report_test();
		logic [16:0] want;
		string name;
		want = expected_store(test_id, instr0, instr1);
		name = test_name(test_id);
		checked = checked + 1;
		if (want[16] && stores == 0)
		begin
			$display("no store seen in test %s", name);
			failed = failed + 1;
		end
		else if (!want[16] && stores != 0)
		begin
			$display("store seen in test %s although the branch should skip it", name);
			failed = failed + 1;
		end
		else if (stores > 1)
		begin
			$display("%0d stores in test %s where one was expected", stores, name);
			failed = failed + 1;
		end
		else if (want[16] && first_data != want[15:0])
		begin
			$display("mismatch %s expected %06o actual %06o", name, want[15:0], first_data);
			failed = failed + 1;
		end
		else if (want[16] && first_adr != STORE_ADDR)
		begin
			$display("mismatch %s address expected %06o actual %06o", name, STORE_ADDR,
				first_adr);
			failed = failed + 1;
		end
		else
		begin
			$display("test %s ok", name);
		end
	endtask

	initial
	begin
		checked = 0;
		failed = 0;
		stores = 0;
		done_q = 1'b0;
		bus_fault = 1'b0;
		first_data = '0;
		first_adr = '0;
	end

	always @(posedge clock)
	begin
		done_q <= done;
		if ((reset || done) && wb_cyc && !bus_fault)
		begin
			$display("bus active during reset or after done in test %0d", test_id);
			failed = failed + 1;
			bus_fault <= 1'b1;
		end
		if (reset)
		begin
			stores <= 0;
		end
		else if (wb_cyc && wb_stb && wb_we && wb_ack)
		begin
			if (stores == 0)
			begin
				first_data <= wb_dat_w;
				first_adr <= wb_adr;
			end
			stores <= stores + 1;
		end
		if (!reset && done && !done_q)
		begin
			report_test();
			bus_fault <= 1'b0;
		end
		if (!reset && done_q && !done)
		begin
			$display("done dropped without reset in test %0d", test_id);
			failed = failed + 1;
		end
	end

endmodule

/* pdp_core.sv */
`timescale 1ns/1ps

module pdp_core (
	input logic clock,
	input logic reset,
	input pdp_core_pkg::word_t start_pc,
	input pdp_core_pkg::word_t end_pc,
	input pdp_core_pkg::word_t wb_dat_r,
	input logic wb_ack,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output pdp_core_pkg::word_t wb_adr,
	output pdp_core_pkg::word_t wb_dat_w,
	output logic done
);

	pdp_core_pkg::reg_index_t rd_a_index;
	pdp_core_pkg::reg_index_t rd_b_index;
	pdp_core_pkg::word_t rd_a_data;
	pdp_core_pkg::word_t rd_b_data;
	logic wr_en;
	pdp_core_pkg::reg_index_t wr_index;
	pdp_core_pkg::word_t wr_data;
	pdp_isa_pkg::inst_class_t inst_class;
	pdp_isa_pkg::single_op_t single_opcode;
	pdp_isa_pkg::double_op_t double_opcode;
	pdp_isa_pkg::branch_op_t branch_op;
	pdp_core_pkg::word_t src_operand;
	pdp_core_pkg::word_t dst_operand;
	logic exec_en;
	pdp_core_pkg::word_t result;
	logic write_result;
	logic branch_taken;
	pdp_core_pkg::word_t single_result;
	pdp_core_pkg::word_t double_result;
	pdp_core_pkg::flags_t single_flags;
	pdp_core_pkg::flags_t double_flags;
	pdp_core_pkg::flags_t flags;
	logic double_writes_back;

	instruction_sequencer u_sequencer (.*);

	register_file u_register_file (.*);

	// single operand instructions work on the destination field
	single_operand_alu u_single_alu (
		.opcode(single_opcode),
		.operand(dst_operand),
		.flags_in(flags),
		.result(single_result),
		.flags_out(single_flags)
	);

	double_operand_alu u_double_alu (
		.opcode(double_opcode),
		.src(src_operand),
		.dst(dst_operand),
		.flags_in(flags),
		.result(double_result),
		.writes_back(double_writes_back),
		.flags_out(double_flags)
	);

	result_merge u_result_merge (.*);

endmodule

/* instruction_sequencer.sv */
`timescale 1ns/1ps

module instruction_sequencer (
	input logic clock,
	input logic reset,
	input pdp_core_pkg::word_t start_pc,
	input pdp_core_pkg::word_t end_pc,
	input pdp_core_pkg::word_t wb_dat_r,
	input logic wb_ack,
	output logic wb_cyc,
	output logic wb_stb,
	output logic wb_we,
	output pdp_core_pkg::word_t wb_adr,
	output pdp_core_pkg::word_t wb_dat_w,
	output pdp_core_pkg::reg_index_t rd_a_index,
	output pdp_core_pkg::reg_index_t rd_b_index,
	input pdp_core_pkg::word_t rd_a_data,
	input pdp_core_pkg::word_t rd_b_data,
	output logic wr_en,
	output pdp_core_pkg::reg_index_t wr_index,
	output pdp_core_pkg::word_t wr_data,
	output pdp_isa_pkg::inst_class_t inst_class,
	output pdp_isa_pkg::single_op_t single_opcode,
	output pdp_isa_pkg::double_op_t double_opcode,
	output pdp_isa_pkg::branch_op_t branch_op,
	output pdp_core_pkg::word_t src_operand,
	output pdp_core_pkg::word_t dst_operand,
	output logic exec_en,
	input pdp_core_pkg::word_t result,
	input logic write_result,
	input logic branch_taken,
	output logic done
);

	pdp_core_pkg::seq_state_t state;
	pdp_core_pkg::seq_state_t next_state;
	pdp_core_pkg::word_t pc;
	pdp_core_pkg::word_t ir;
	pdp_core_pkg::word_t result_q;
	logic store_q;
	pdp_isa_pkg::mode_t src_mode;
	pdp_isa_pkg::mode_t dst_mode;
	logic [7:0] offset;
	pdp_core_pkg::word_t branch_disp;
	logic src_from_bus;
	logic dst_from_bus;
	logic bus_read;
	logic bus_write;

	// decode straight from the instruction register
	assign inst_class = pdp_isa_pkg::classify(ir);
	assign single_opcode = pdp_isa_pkg::single_op_t'(ir[15:6]);
	assign double_opcode = pdp_isa_pkg::double_op_t'(ir[15:12]);
	assign branch_op = pdp_isa_pkg::branch_op_t'(ir[15:8]);
	assign src_mode = pdp_isa_pkg::mode_t'(ir[pdp_isa_pkg::SRC_MODE_LSB +: 3]);
	assign dst_mode = pdp_isa_pkg::mode_t'(ir[pdp_isa_pkg::DST_MODE_LSB +: 3]);
	assign rd_a_index = ir[pdp_isa_pkg::SRC_REG_LSB +: 3];
	assign rd_b_index = ir[pdp_isa_pkg::DST_REG_LSB +: 3];
	assign offset = ir[pdp_isa_pkg::BRANCH_OFFSET_LSB +: 8];
	// offset counts words
	assign branch_disp = {{7{offset[7]}}, offset, 1'b0};

	// deferred operands come over the bus, MOV does not read its destination
	assign src_from_bus = inst_class == pdp_isa_pkg::DOUBLE_OPERAND
		&& src_mode == pdp_isa_pkg::MODE_DEFERRED;
	assign dst_from_bus = dst_mode == pdp_isa_pkg::MODE_DEFERRED
		&& (inst_class == pdp_isa_pkg::SINGLE_OPERAND
		|| (inst_class == pdp_isa_pkg::DOUBLE_OPERAND && double_opcode != pdp_isa_pkg::MOV));

	assign bus_read = state inside {pdp_core_pkg::FETCH, pdp_core_pkg::READ_SRC,
		pdp_core_pkg::READ_DST};
	assign bus_write = state == pdp_core_pkg::WRITE_DST && store_q
		&& dst_mode == pdp_isa_pkg::MODE_DEFERRED;

	// wishbone classic, strobes follow the state so they drop after ack
	assign wb_cyc = bus_read || bus_write;
	assign wb_stb = bus_read || bus_write;
	assign wb_we = bus_write;
	assign wb_dat_w = result_q;

	always_comb
	begin
		case (state)
			pdp_core_pkg::READ_SRC: wb_adr = rd_a_data;
			pdp_core_pkg::READ_DST, pdp_core_pkg::WRITE_DST: wb_adr = rd_b_data;
			default: wb_adr = pc;
		endcase
	end

	assign wr_en = state == pdp_core_pkg::WRITE_DST && store_q
		&& dst_mode == pdp_isa_pkg::MODE_REGISTER;
	assign wr_index = rd_b_index;
	assign wr_data = result_q;
	assign exec_en = state == pdp_core_pkg::EXECUTE;
	assign done = state == pdp_core_pkg::DONE;

	always_comb
	begin
		next_state = state;
		case (state)
			pdp_core_pkg::RESET_PC:
				next_state = pdp_core_pkg::FETCH;
			pdp_core_pkg::FETCH:
				if (wb_ack)
					next_state = pdp_core_pkg::DECODE;
			pdp_core_pkg::DECODE:
				if (src_from_bus)
					next_state = pdp_core_pkg::READ_SRC;
				else if (dst_from_bus)
					next_state = pdp_core_pkg::READ_DST;
				else
					next_state = pdp_core_pkg::EXECUTE;
			pdp_core_pkg::READ_SRC:
				if (wb_ack)
					next_state = dst_from_bus ? pdp_core_pkg::READ_DST : pdp_core_pkg::EXECUTE;
			pdp_core_pkg::READ_DST:
				if (wb_ack)
					next_state = pdp_core_pkg::EXECUTE;
			pdp_core_pkg::EXECUTE:
				next_state = pdp_core_pkg::WRITE_DST;
			pdp_core_pkg::WRITE_DST:
				if (!bus_write || wb_ack)
					next_state = pdp_core_pkg::CHECK_END;
			pdp_core_pkg::CHECK_END:
				next_state = (pc >= end_pc) ? pdp_core_pkg::DONE : pdp_core_pkg::FETCH;
			pdp_core_pkg::DONE:
				next_state = pdp_core_pkg::DONE;
			default:
				next_state = pdp_core_pkg::RESET_PC;
		endcase
	end

	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			state <= pdp_core_pkg::RESET_PC;
			pc <= '0;
			store_q <= 1'b0;
		end
		else
		begin
			state <= next_state;
			if (state == pdp_core_pkg::RESET_PC)
				pc <= start_pc;
			// TST only sets flags
			if (state == pdp_core_pkg::EXECUTE)
				store_q <= write_result && !(inst_class == pdp_isa_pkg::SINGLE_OPERAND
					&& single_opcode == pdp_isa_pkg::TST);
			if (state == pdp_core_pkg::WRITE_DST && next_state == pdp_core_pkg::CHECK_END)
				pc <= branch_taken ? pc + 16'd2 + branch_disp : pc + 16'd2;
		end
	end

	// result is latched since the rotates see the new carry after EXECUTE
	always_ff @(posedge clock)
	begin
		if (state == pdp_core_pkg::FETCH && wb_ack)
			ir <= wb_dat_r;
		if (state == pdp_core_pkg::DECODE)
		begin
			src_operand <= rd_a_data;
			dst_operand <= rd_b_data;
		end
		if (state == pdp_core_pkg::READ_SRC && wb_ack)
			src_operand <= wb_dat_r;
		if (state == pdp_core_pkg::READ_DST && wb_ack)
			dst_operand <= wb_dat_r;
		if (state == pdp_core_pkg::EXECUTE)
			result_q <= result;
	end

endmodule

/* result_merge.sv */
`timescale 1ns/1ps

module result_merge (
	input logic clock,
	input logic reset,
	input pdp_isa_pkg::inst_class_t inst_class,
	input logic exec_en,
	input pdp_core_pkg::word_t single_result,
	input pdp_core_pkg::word_t double_result,
	input pdp_core_pkg::flags_t single_flags,
	input pdp_core_pkg::flags_t double_flags,
	input logic double_writes_back,
	input pdp_isa_pkg::branch_op_t branch_op,
	output pdp_core_pkg::word_t result,
	output logic write_result,
	output pdp_core_pkg::flags_t flags,
	output logic branch_taken
);

	logic condition;

	always_comb
	begin
		case (inst_class)
			pdp_isa_pkg::SINGLE_OPERAND:
			begin
				result = single_result;
				write_result = 1'b1;
			end
			pdp_isa_pkg::DOUBLE_OPERAND:
			begin
				result = double_result;
				write_result = double_writes_back;
			end
			default:
			begin
				result = '0;
				write_result = 1'b0;
			end
		endcase
	end

	// processor status word, branches and unsupported words keep it
	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
			flags <= '0;
		else if (exec_en && inst_class == pdp_isa_pkg::SINGLE_OPERAND)
			flags <= single_flags;
		else if (exec_en && inst_class == pdp_isa_pkg::DOUBLE_OPERAND)
			flags <= double_flags;
	end

	always_comb
	begin
		case (branch_op)
			pdp_isa_pkg::BR: condition = 1'b1;
			pdp_isa_pkg::BNE: condition = !flags.z;
			pdp_isa_pkg::BEQ: condition = flags.z;
			pdp_isa_pkg::BGE: condition = !(flags.n ^ flags.v);
			pdp_isa_pkg::BLT: condition = flags.n ^ flags.v;
			pdp_isa_pkg::BGT: condition = !(flags.z | (flags.n ^ flags.v));
			pdp_isa_pkg::BLE: condition = flags.z | (flags.n ^ flags.v);
			pdp_isa_pkg::BPL: condition = !flags.n;
			pdp_isa_pkg::BMI: condition = flags.n;
			pdp_isa_pkg::BHI: condition = !(flags.c | flags.z);
			pdp_isa_pkg::BLOS: condition = flags.c | flags.z;
			pdp_isa_pkg::BVC: condition = !flags.v;
			pdp_isa_pkg::BVS: condition = flags.v;
			pdp_isa_pkg::BCC: condition = !flags.c;
			pdp_isa_pkg::BCS: condition = flags.c;
			default: condition = 1'b0;
		endcase
	end

	assign branch_taken = (inst_class == pdp_isa_pkg::CONDITIONAL_BRANCH) && condition;

endmodule

/* double_operand_alu.sv */
`timescale 1ns/1ps

module double_operand_alu (
	input pdp_isa_pkg::double_op_t opcode,
	input pdp_core_pkg::word_t src,
	input pdp_core_pkg::word_t dst,
	input pdp_core_pkg::flags_t flags_in,
	output pdp_core_pkg::word_t result,
	output logic writes_back,
	output pdp_core_pkg::flags_t flags_out
);

	// bit 16 holds carry out of ADD, borrow out of CMP and SUB
	logic [16:0] sum;
	logic carry;
	logic overflow;

	always_comb
	begin
		sum = '0;
		result = src;
		carry = flags_in.c;
		overflow = 1'b0;
		writes_back = 1'b1;
		case (opcode)
			pdp_isa_pkg::MOV:
				result = src;
			pdp_isa_pkg::CMP:
			begin
				sum = {1'b0, src} - {1'b0, dst};
				result = sum[15:0];
				carry = sum[16];
				overflow = (src[15] != dst[15]) && (dst[15] == result[15]);
				writes_back = 1'b0;
			end
			pdp_isa_pkg::BIT:
			begin
				result = src & dst;
				writes_back = 1'b0;
			end
			pdp_isa_pkg::BIC:
				result = ~src & dst;
			pdp_isa_pkg::BIS:
				result = src | dst;
			pdp_isa_pkg::ADD:
			begin
				sum = {1'b0, dst} + {1'b0, src};
				result = sum[15:0];
				carry = sum[16];
				overflow = (src[15] == dst[15]) && (result[15] != src[15]);
			end
			pdp_isa_pkg::SUB:
			begin
				sum = {1'b0, dst} - {1'b0, src};
				result = sum[15:0];
				carry = sum[16];
				overflow = (src[15] != dst[15]) && (result[15] == src[15]);
			end
			default:
			begin
				result = dst;
				overflow = flags_in.v;
				writes_back = 1'b0;
			end
		endcase
	end

	assign flags_out.n = result[15];
	assign flags_out.z = result == 16'd0;
	assign flags_out.v = overflow;
	assign flags_out.c = carry;

endmodule

/* single_operand_alu.sv */
`timescale 1ns/1ps

module single_operand_alu (
	input pdp_isa_pkg::single_op_t opcode,
	input pdp_core_pkg::word_t operand,
	input pdp_core_pkg::flags_t flags_in,
	output pdp_core_pkg::word_t result,
	output pdp_core_pkg::flags_t flags_out
);

	logic carry;
	logic overflow;
	logic is_shift;

	always_comb
	begin
		result = operand;
		carry = flags_in.c;
		overflow = flags_in.v;
		is_shift = 1'b0;
		case (opcode)
			pdp_isa_pkg::SWAB:
			begin
				result = {operand[7:0], operand[15:8]};
				carry = 1'b0;
				overflow = 1'b0;
			end
			pdp_isa_pkg::CLR:
			begin
				result = '0;
				carry = 1'b0;
				overflow = 1'b0;
			end
			pdp_isa_pkg::COM:
			begin
				result = ~operand;
				carry = 1'b1;
				overflow = 1'b0;
			end
			// INC and DEC leave the carry alone
			pdp_isa_pkg::INC:
			begin
				result = operand + 16'd1;
				overflow = operand == 16'o077777;
			end
			pdp_isa_pkg::DEC:
			begin
				result = operand - 16'd1;
				overflow = operand == 16'o100000;
			end
			pdp_isa_pkg::NEG:
			begin
				result = 16'd0 - operand;
				overflow = result == 16'o100000;
				carry = result != 16'd0;
			end
			pdp_isa_pkg::TST:
			begin
				carry = 1'b0;
				overflow = 1'b0;
			end
			// rotates go through the carry bit
			pdp_isa_pkg::ROR:
			begin
				{result, carry} = {flags_in.c, operand};
				is_shift = 1'b1;
			end
			pdp_isa_pkg::ROL:
			begin
				{carry, result} = {operand, flags_in.c};
				is_shift = 1'b1;
			end
			pdp_isa_pkg::ASR:
			begin
				{result, carry} = {operand[15], operand};
				is_shift = 1'b1;
			end
			pdp_isa_pkg::ASL:
			begin
				{carry, result} = {operand, 1'b0};
				is_shift = 1'b1;
			end
			default:
			begin
				result = operand;
			end
		endcase
	end

	// SWAB reports on the new low byte
	assign flags_out.n = (opcode == pdp_isa_pkg::SWAB) ? result[7] : result[15];
	assign flags_out.z = (opcode == pdp_isa_pkg::SWAB) ? (result[7:0] == 8'd0)
		: (result == 16'd0);
	assign flags_out.v = is_shift ? (flags_out.n ^ carry) : overflow;
	assign flags_out.c = carry;

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file (
	input logic clock,
	input logic reset,
	input pdp_core_pkg::reg_index_t rd_a_index,
	input pdp_core_pkg::reg_index_t rd_b_index,
	output pdp_core_pkg::word_t rd_a_data,
	output pdp_core_pkg::word_t rd_b_data,
	input logic wr_en,
	input pdp_core_pkg::reg_index_t wr_index,
	input pdp_core_pkg::word_t wr_data
);

	pdp_core_pkg::word_t regs [0:7];

	// preset contents so test programs have known operands
	always_ff @(posedge clock, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= pdp_core_pkg::REG_RESET_VALUES[i];
		end
		else if (wr_en)
		begin
			regs[wr_index] <= wr_data;
		end
	end

	assign rd_a_data = regs[rd_a_index];
	assign rd_b_data = regs[rd_b_index];

endmodule

/* pdp_core_pkg.sv */
package pdp_core_pkg;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_index_t;

	// condition codes, same order as the low nibble of the PSW
	typedef struct packed
	{
		logic n;
		logic z;
		logic v;
		logic c;
	} flags_t;

	typedef enum logic [3:0]
	{
		RESET_PC,
		FETCH,
		DECODE,
		READ_SRC,
		READ_DST,
		EXECUTE,
		WRITE_DST,
		CHECK_END,
		DONE
	} seq_state_t;

	// R0..R7 after reset
	localparam word_t [0:7] REG_RESET_VALUES = {
		16'o000014, 16'o000002, 16'o000004, 16'o000012,
		16'o000010, 16'o000020, 16'o000000, 16'o000000
	};

endpackage

/* pdp_isa_pkg.sv */
package pdp_isa_pkg;

	// instruction field positions, all fields are 3 bits except the branch offset
	localparam int DST_REG_LSB = 0;
	localparam int DST_MODE_LSB = 3;
	localparam int SRC_REG_LSB = 6;
	localparam int SRC_MODE_LSB = 9;
	localparam int BRANCH_OFFSET_LSB = 0;

	// bits 15..6
	typedef enum logic [9:0]
	{
		SWAB = 10'o003,
		CLR = 10'o050,
		COM = 10'o051,
		INC = 10'o052,
		DEC = 10'o053,
		NEG = 10'o054,
		TST = 10'o057,
		ROR = 10'o060,
		ROL = 10'o061,
		ASR = 10'o062,
		ASL = 10'o063
	} single_op_t;

	// bits 15..12, word forms only
	typedef enum logic [3:0]
	{
		MOV = 4'o01,
		CMP = 4'o02,
		BIT = 4'o03,
		BIC = 4'o04,
		BIS = 4'o05,
		ADD = 4'o06,
		SUB = 4'o16
	} double_op_t;

	// bits 15..8
	typedef enum logic [7:0]
	{
		BR = 8'h01,
		BNE = 8'h02,
		BEQ = 8'h03,
		BGE = 8'h04,
		BLT = 8'h05,
		BGT = 8'h06,
		BLE = 8'h07,
		BPL = 8'h80,
		BMI = 8'h81,
		BHI = 8'h82,
		BLOS = 8'h83,
		BVC = 8'h84,
		BVS = 8'h85,
		BCC = 8'h86,
		BCS = 8'h87
	} branch_op_t;

	typedef enum logic [1:0]
	{
		SINGLE_OPERAND,
		DOUBLE_OPERAND,
		CONDITIONAL_BRANCH,
		UNSUPPORTED
	} inst_class_t;

	typedef enum logic [2:0]
	{
		MODE_REGISTER = 3'd0,
		MODE_DEFERRED = 3'd1
	} mode_t;

	// anything outside the subset or using other modes is unsupported
	function automatic inst_class_t classify(input logic [15:0] instr);
		logic src_ok;
		logic dst_ok;
		inst_class_t kind;
		src_ok = instr[SRC_MODE_LSB +: 3] inside {MODE_REGISTER, MODE_DEFERRED};
		dst_ok = instr[DST_MODE_LSB +: 3] inside {MODE_REGISTER, MODE_DEFERRED};
		kind = UNSUPPORTED;
		if (instr[15:12] inside {MOV, CMP, BIT, BIC, BIS, ADD, SUB})
		begin
			if (src_ok && dst_ok)
				kind = DOUBLE_OPERAND;
		end
		else if (instr[15:8] inside {BR, BNE, BEQ, BGE, BLT, BGT, BLE, BPL, BMI,
			BHI, BLOS, BVC, BVS, BCC, BCS})
		begin
			kind = CONDITIONAL_BRANCH;
		end
		else if (instr[15:6] inside {SWAB, CLR, COM, INC, DEC, NEG, TST, ROR, ROL,
			ASR, ASL})
		begin
			if (dst_ok)
				kind = SINGLE_OPERAND;
		end
		return kind;
	endfunction

endpackage
